/* verilog/replicator_pkg.sv */
// ######################################
// Widths and types shared by the replicator.
// The connection vector is fixed at 16 entries, so the qid and the copy
// count widths follow from it.
// ######################################
`default_nettype none

package replicator_pkg;

	localparam int CONN_NUM = 16;

	typedef logic [CONN_NUM-1:0] conn_vec_t;
	typedef logic [3:0]          conn_id_t;
	typedef logic [4:0]          copy_id_t;   // Holds up to CONN_NUM.
	typedef logic [2:0]          pri_t;
	typedef logic [6:0]          qid_t;       // Priority above connection.
	typedef logic [15:0]         buf_ptr_t;
	typedef logic [13:0]         pkt_len_t;
	typedef logic [3:0]          port_t;

	// ######################################
	// Descriptor held in the unicast and multicast queues
	// ######################################
	typedef struct packed
	{
		conn_vec_t vec;
		pri_t      pri;
		buf_ptr_t  buf_ptr;
		pkt_len_t  len;
		port_t     src_port;
	} queue_entry_t;

	typedef enum logic [1:0]
	{
		reason_flag          = 2'd0,
		reason_empty_vec     = 2'd1,
		reason_mcast_blocked = 2'd2,
		reason_queue_full    = 2'd3
	} discard_reason_t;

	typedef enum logic
	{
		idle    = 1'b0,
		copying = 1'b1
	} engine_state_t;

endpackage

`default_nettype wire

/* verilog/queue_if.sv */
// ######################################
// Link between a descriptor queue, its writer and its reader.
// wr is never raised while full, and rd never while empty.
// head is valid whenever empty is low.
// ######################################
`default_nettype none

interface queue_if
	import replicator_pkg::*;
();

	logic         wr;
	queue_entry_t entry;
	logic         full;
	logic         rd;
	queue_entry_t head;
	logic         empty;

	modport writer (output wr, output entry, input full);

	modport reader (output rd, input head, input empty);

	modport fifo (
		input  wr,
		input  entry,
		input  rd,
		output full,
		output empty,
		output head
	);

endinterface

`default_nettype wire

/* verilog/enq_classifier.sv */
// ######################################
// Enqueue classifier. A request registered at edge N is written to its
// queue, or reported on the discard port, at edge N+1.
// There is no back-pressure toward the request source, so a request
// that meets a full queue is discarded.
// ######################################
`default_nettype none

module enq_classifier
	import replicator_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            enq_req,
	input  logic            enq_discard,
	input  logic            enq_allow_mcast,
	input  conn_vec_t       enq_vec,
	input  pri_t            enq_pri,
	input  buf_ptr_t        enq_buf_ptr,
	input  pkt_len_t        enq_len,
	input  port_t           enq_src_port,
	queue_if.writer         ucast_q,
	queue_if.writer         mcast_q,
	output logic            discard_req,
	output discard_reason_t discard_reason,
	output buf_ptr_t        discard_buf_ptr,
	output pkt_len_t        discard_len,
	output port_t           discard_src_port
);

	logic            req_d1;
	logic            discard_d1;
	logic            allow_mcast_d1;
	queue_entry_t    in_entry;
	copy_id_t        copy_cnt;
	logic            ucast_wr;
	logic            mcast_wr;
	logic            drop;
	discard_reason_t reason;

	function automatic copy_id_t count_bits(input conn_vec_t vec);
		copy_id_t sum;
		sum = '0;
		for (int i = 0; i < CONN_NUM; i++)
			sum = sum + copy_id_t'(vec[i]);
		return sum;
	endfunction

	// ######################################
	// Request register
	// ######################################
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			req_d1 <= 1'b0;
		else
			req_d1 <= enq_req;
	end

	always_ff @(posedge clk)
	begin
		discard_d1        <= enq_discard;
		allow_mcast_d1    <= enq_allow_mcast;
		in_entry.vec      <= enq_vec;
		in_entry.pri      <= enq_pri;
		in_entry.buf_ptr  <= enq_buf_ptr;
		in_entry.len      <= enq_len;
		in_entry.src_port <= enq_src_port;
	end

	assign copy_cnt = count_bits(in_entry.vec);

	// ######################################
	// Steering, first match wins
	// ######################################
	always_comb
	begin
		ucast_wr = 1'b0;
		mcast_wr = 1'b0;
		drop     = 1'b0;
		reason   = reason_flag;
		if (req_d1)
		begin
			if (discard_d1)
				drop = 1'b1;
			else if (copy_cnt == copy_id_t'(0))
			begin
				drop   = 1'b1;
				reason = reason_empty_vec;
			end
			else if (copy_cnt == copy_id_t'(1))
			begin
				drop     = ucast_q.full;
				ucast_wr = !ucast_q.full;
				reason   = reason_queue_full;
			end
			else if (!allow_mcast_d1)
			begin
				drop   = 1'b1;
				reason = reason_mcast_blocked;
			end
			else
			begin
				drop     = mcast_q.full;
				mcast_wr = !mcast_q.full;
				reason   = reason_queue_full;
			end
		end
	end

	assign ucast_q.wr    = ucast_wr;
	assign ucast_q.entry = in_entry;
	assign mcast_q.wr    = mcast_wr;
	assign mcast_q.entry = in_entry;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			discard_req <= 1'b0;
		else
			discard_req <= drop;
	end

	always_ff @(posedge clk)
	begin
		if (drop)
		begin
			discard_reason   <= reason;
			discard_buf_ptr  <= in_entry.buf_ptr;
			discard_len      <= in_entry.len;
			discard_src_port <= in_entry.src_port;
		end
	end

	// Each request is either written to a queue or discarded, never both.
	a_write_or_discard: assert property (@(posedge clk) disable iff (!rst_n)
		enq_req |-> ##2 (discard_req != $past(ucast_q.wr || mcast_q.wr)));

endmodule

`default_nettype wire

/* verilog/desc_fifo.sv */
// ######################################
// Synchronous descriptor queue of 2**DEPTH_BITS entries.
// head shows the oldest entry with no read latency.
// ######################################
`default_nettype none

module desc_fifo
	import replicator_pkg::*;
#(
	parameter int DEPTH_BITS = 4
)(
	input logic   clk,
	input logic   rst_n,
	queue_if.fifo q
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	queue_entry_t          mem [DEPTH];
	logic [DEPTH_BITS:0]   wr_ptr;   // Extra bit tells full from empty.
	logic [DEPTH_BITS:0]   rd_ptr;
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = q.wr && !q.full;
	assign do_rd = q.rd && !q.empty;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr[DEPTH_BITS-1:0]] <= q.entry;
	end

	// ######################################
	// Status and head
	// ######################################
	assign q.empty = (wr_ptr == rd_ptr);
	assign q.full  = (wr_ptr[DEPTH_BITS] != rd_ptr[DEPTH_BITS]) &&
		(wr_ptr[DEPTH_BITS-1:0] == rd_ptr[DEPTH_BITS-1:0]);
	assign q.head  = mem[rd_ptr[DEPTH_BITS-1:0]];

	// Writer and reader must honour the queue status.
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(q.wr && q.full));

	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(q.rd && q.empty));

endmodule

`default_nettype wire

/* verilog/copy_engine.sv */
// ######################################
// Copy engine. Unicast wins at each packet boundary.
// One registered copy per set bit, lowest connection first.
// rep_bp holds the engine in place; one idle cycle sits between packets.
// ######################################
`default_nettype none

module copy_engine
	import replicator_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rep_bp,
	queue_if.reader  ucast_q,
	queue_if.reader  mcast_q,
	output logic     rep_req,
	output logic     rep_ucast,
	output logic     rep_last,
	output copy_id_t rep_copy_id,
	output qid_t     rep_qid,
	output buf_ptr_t rep_buf_ptr,
	output pkt_len_t rep_len,
	output port_t    rep_src_port
);

	engine_state_t state;
	queue_entry_t  cur;
	logic          cur_ucast;
	conn_vec_t     rem_vec;
	conn_vec_t     rem_next;
	conn_id_t      low_conn;
	copy_id_t      copy_cnt;
	logic          pop_u;
	logic          pop_m;
	logic          issue;

	function automatic conn_id_t lowest_bit(input conn_vec_t vec);
		conn_id_t idx;
		idx = '0;
		for (int i = CONN_NUM - 1; i >= 0; i--)
		begin
			if (vec[i])
				idx = conn_id_t'(i);
		end
		return idx;
	endfunction

	// ######################################
	// Queue arbitration
	// ######################################
	assign pop_u = (state == idle) && !ucast_q.empty;
	assign pop_m = (state == idle) && ucast_q.empty && !mcast_q.empty;

	assign ucast_q.rd = pop_u;
	assign mcast_q.rd = pop_m;

	assign issue    = (state == copying) && !rep_bp;
	assign low_conn = lowest_bit(rem_vec);
	assign rem_next = rem_vec & (rem_vec - conn_vec_t'(1));   // Drop lowest bit.

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= idle;
			rem_vec  <= '0;
			copy_cnt <= '0;
			rep_req  <= 1'b0;
		end
		else
		begin
			rep_req <= issue;
			case (state)
				idle:
				begin
					if (pop_u || pop_m)
					begin
						rem_vec  <= pop_u ? ucast_q.head.vec : mcast_q.head.vec;
						copy_cnt <= '0;
						state    <= copying;
					end
				end
				copying:
				begin
					if (!rep_bp)
					begin
						rem_vec  <= rem_next;
						copy_cnt <= copy_cnt + copy_id_t'(1);
						if (rem_next == '0)
							state <= idle;   // Last copy issued.
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop_u || pop_m)
		begin
			cur       <= pop_u ? ucast_q.head : mcast_q.head;
			cur_ucast <= pop_u;
		end
	end

	// ######################################
	// Copy outputs
	// ######################################
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			rep_ucast    <= cur_ucast;
			rep_last     <= (rem_next == '0);
			rep_copy_id  <= copy_cnt;
			rep_qid      <= {cur.pri, low_conn};
			rep_buf_ptr  <= cur.buf_ptr;
			rep_len      <= cur.len;
			rep_src_port <= cur.src_port;
		end
	end

	// Back-pressure seen at an edge stops the copy of the next cycle
	// and holds the position within the packet.
	a_bp_stalls: assert property (@(posedge clk) disable iff (!rst_n)
		rep_bp |=> !rep_req &&
			($past(state) != copying || ($stable(rem_vec) && $stable(copy_cnt))));

endmodule

`default_nettype wire

/* verilog/packet_replicator.sv */
// ######################################
// Packet replicator top level.
// enq_req is a one-cycle strobe with no back-pressure.
// Queue depths are 2**UCAST_DEPTH_BITS and 2**MCAST_DEPTH_BITS.
// ######################################
`default_nettype none

module packet_replicator
	import replicator_pkg::*;
#(
	parameter int UCAST_DEPTH_BITS = 4,
	parameter int MCAST_DEPTH_BITS = 3
)(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            enq_req,
	input  logic            enq_discard,
	input  logic            enq_allow_mcast,
	input  conn_vec_t       enq_vec,
	input  pri_t            enq_pri,
	input  buf_ptr_t        enq_buf_ptr,
	input  pkt_len_t        enq_len,
	input  port_t           enq_src_port,
	input  logic            rep_bp,
	output logic            rep_req,
	output logic            rep_ucast,
	output logic            rep_last,
	output copy_id_t        rep_copy_id,
	output qid_t            rep_qid,
	output buf_ptr_t        rep_buf_ptr,
	output pkt_len_t        rep_len,
	output port_t           rep_src_port,
	output logic            discard_req,
	output discard_reason_t discard_reason,
	output buf_ptr_t        discard_buf_ptr,
	output pkt_len_t        discard_len,
	output port_t           discard_src_port
);

	queue_if ucast_if ();
	queue_if mcast_if ();

	enq_classifier classifier_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.enq_req          (enq_req),
		.enq_discard      (enq_discard),
		.enq_allow_mcast  (enq_allow_mcast),
		.enq_vec          (enq_vec),
		.enq_pri          (enq_pri),
		.enq_buf_ptr      (enq_buf_ptr),
		.enq_len          (enq_len),
		.enq_src_port     (enq_src_port),
		.ucast_q          (ucast_if.writer),
		.mcast_q          (mcast_if.writer),
		.discard_req      (discard_req),
		.discard_reason   (discard_reason),
		.discard_buf_ptr  (discard_buf_ptr),
		.discard_len      (discard_len),
		.discard_src_port (discard_src_port)
	);

	desc_fifo #(.DEPTH_BITS(UCAST_DEPTH_BITS)) ucast_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.q     (ucast_if.fifo)
	);

	desc_fifo #(.DEPTH_BITS(MCAST_DEPTH_BITS)) mcast_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.q     (mcast_if.fifo)
	);

	copy_engine engine_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.rep_bp       (rep_bp),
		.ucast_q      (ucast_if.reader),
		.mcast_q      (mcast_if.reader),
		.rep_req      (rep_req),
		.rep_ucast    (rep_ucast),
		.rep_last     (rep_last),
		.rep_copy_id  (rep_copy_id),
		.rep_qid      (rep_qid),
		.rep_buf_ptr  (rep_buf_ptr),
		.rep_len      (rep_len),
		.rep_src_port (rep_src_port)
	);

endmodule

`default_nettype wire

/* bench/replicator_tb.sv */
// ######################################
// Testbench for the packet replicator, with a reference model of the
// expected copies and discards. The model treats the engine as holding
// one packet beyond each queue's depth. Copies are matched per queue,
// since unicast may pass waiting multicast at a packet boundary.
// ######################################
`default_nettype none

module replicator_tb
	import replicator_pkg::*;
();

	localparam int UCAST_DEPTH_BITS = 4;
	localparam int MCAST_DEPTH_BITS = 3;
	localparam int UCAST_CAP = (1 << UCAST_DEPTH_BITS) + 1;   // Queue plus engine slot.
	localparam int MCAST_CAP = (1 << MCAST_DEPTH_BITS) + 1;

	typedef struct packed
	{
		logic     ucast;
		logic     last;
		copy_id_t copy_id;
		qid_t     qid;
		buf_ptr_t buf_ptr;
		pkt_len_t len;
		port_t    src_port;
	} copy_t;

	typedef struct packed
	{
		discard_reason_t reason;
		buf_ptr_t        buf_ptr;
		pkt_len_t        len;
		port_t           src_port;
		int              due;      // Cycle in which discard_req is sampled high.
	} disc_t;

	logic            clk;
	logic            rst_n;
	logic            enq_req;
	logic            enq_discard;
	logic            enq_allow_mcast;
	conn_vec_t       enq_vec;
	pri_t            enq_pri;
	buf_ptr_t        enq_buf_ptr;
	pkt_len_t        enq_len;
	port_t           enq_src_port;
	logic            rep_bp;
	logic            rep_req;
	logic            rep_ucast;
	logic            rep_last;
	copy_id_t        rep_copy_id;
	qid_t            rep_qid;
	buf_ptr_t        rep_buf_ptr;
	pkt_len_t        rep_len;
	port_t           rep_src_port;
	logic            discard_req;
	discard_reason_t discard_reason;
	buf_ptr_t        discard_buf_ptr;
	pkt_len_t        discard_len;
	port_t           discard_src_port;

	copy_t ucopy_q[$];
	copy_t mcopy_q[$];
	disc_t disc_q[$];
	copy_t ucopy_head;
	copy_t mcopy_head;
	copy_t copy_head;
	disc_t disc_head;
	copy_t copy_seen;
	disc_t disc_seen;
	logic  ucopy_pending;
	logic  mcopy_pending;
	logic  copy_pending;
	logic  disc_pending;
	logic  in_pkt;
	logic  pkt_ucast;
	int    cyc;
	int    seed;
	int    errors;
	int    checks;
	int    tests;
	int    ucast_occ;
	int    mcast_occ;
	int    next_ptr;

	packet_replicator #(
		.UCAST_DEPTH_BITS (UCAST_DEPTH_BITS),
		.MCAST_DEPTH_BITS (MCAST_DEPTH_BITS)
	) packet_replicator_i (.*);

	assign copy_seen = {rep_ucast, rep_last, rep_copy_id, rep_qid, rep_buf_ptr, rep_len,
		rep_src_port};
	assign disc_seen = {discard_reason, discard_buf_ptr, discard_len, discard_src_port, cyc};

	// Each copy is compared with the head of the queue it claims to come from.
	assign copy_pending = rep_ucast ? ucopy_pending : mcopy_pending;
	assign copy_head    = rep_ucast ? ucopy_head : mcopy_head;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic void refresh_heads();
		ucopy_pending = (ucopy_q.size() > 0);
		mcopy_pending = (mcopy_q.size() > 0);
		disc_pending  = (disc_q.size() > 0);
		ucopy_head    = ucopy_pending ? ucopy_q[0] : '0;
		mcopy_head    = mcopy_pending ? mcopy_q[0] : '0;
		disc_head     = disc_pending ? disc_q[0] : '0;
	endfunction

	// ######################################
	// Model consumption of observed events
	// ######################################
	always @(posedge clk)
	begin
		if (rst_n && rep_req && rep_ucast && ucopy_q.size() > 0)
		begin
			if (ucopy_q[0].last)
				ucast_occ--;
			in_pkt    = !ucopy_q[0].last;
			pkt_ucast = 1'b1;
			ucopy_q.pop_front();
			checks++;
		end
		else if (rst_n && rep_req && !rep_ucast && mcopy_q.size() > 0)
		begin
			if (mcopy_q[0].last)
				mcast_occ--;
			in_pkt    = !mcopy_q[0].last;
			pkt_ucast = 1'b0;
			mcopy_q.pop_front();
			checks++;
		end
		if (rst_n && discard_req && disc_q.size() > 0)
		begin
			disc_q.pop_front();
			checks++;
		end
		cyc++;
		refresh_heads();
	end

	task automatic show_field_diff(input string name, input int exp, input int got);
		if (exp != got)
			$display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, got);
	endtask

	task automatic copy_mismatch(input logic pending, input copy_t exp, input copy_t got);
		errors++;
		if (!pending)
			$display("At %0t a copy came out when none was expected", $time);
		else
		begin
			show_field_diff("rep_ucast", exp.ucast, got.ucast);
			show_field_diff("rep_last", exp.last, got.last);
			show_field_diff("rep_copy_id", exp.copy_id, got.copy_id);
			show_field_diff("rep_qid", exp.qid, got.qid);
			show_field_diff("rep_buf_ptr", exp.buf_ptr, got.buf_ptr);
			show_field_diff("rep_len", exp.len, got.len);
			show_field_diff("rep_src_port", exp.src_port, got.src_port);
		end
	endtask

	task automatic discard_mismatch(input logic pending, input disc_t exp, input disc_t got);
		errors++;
		if (!pending)
			$display("At %0t a discard came out when none was expected", $time);
		else
		begin
			show_field_diff("discard_req cycle", exp.due, got.due);
			show_field_diff("discard_reason", exp.reason, got.reason);
			show_field_diff("discard_buf_ptr", exp.buf_ptr, got.buf_ptr);
			show_field_diff("discard_len", exp.len, got.len);
			show_field_diff("discard_src_port", exp.src_port, got.src_port);
		end
	endtask

	// ######################################
	// Checks
	// ######################################
	a_copy: assert property (@(posedge clk) disable iff (!rst_n)
		rep_req |-> copy_pending && copy_seen == copy_head)
		else copy_mismatch($sampled(copy_pending), $sampled(copy_head), $sampled(copy_seen));

	a_no_interleave: assert property (@(posedge clk) disable iff (!rst_n)
		rep_req && in_pkt |-> rep_ucast == pkt_ucast)
		else
		begin
			errors++;
			$display("At %0t copies of two packets were interleaved", $time);
		end

	a_discard: assert property (@(posedge clk) disable iff (!rst_n)
		discard_req |-> disc_pending && disc_seen == disc_head)
		else discard_mismatch($sampled(disc_pending), $sampled(disc_head), $sampled(disc_seen));

	a_discard_due: assert property (@(posedge clk) disable iff (!rst_n)
		disc_pending && disc_head.due == cyc |-> discard_req)
		else
		begin
			errors++;
			$display("At %0t a discard was due but discard_req stayed low", $time);
		end

	a_bp_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		rep_bp |=> !rep_req)
		else
		begin
			errors++;
			$display("At %0t rep_req rose while back-pressure was held", $time);
		end

	// ######################################
	// Stimulus and expected results
	// ######################################
	task automatic send_packet(input logic disc, input logic allow, input conn_vec_t vec);
		copy_t c;
		disc_t d;
		int    n;
		int    k;
		logic  drop;
		@(negedge clk);
		enq_req         = 1'b1;
		enq_discard     = disc;
		enq_allow_mcast = allow;
		enq_vec         = vec;
		enq_pri         = pri_t'($random(seed));
		enq_buf_ptr     = buf_ptr_t'(next_ptr);
		enq_len         = pkt_len_t'($random(seed));
		enq_src_port    = port_t'($random(seed));
		next_ptr++;
		n = 0;
		for (int i = 0; i < CONN_NUM; i++)
			n += vec[i];
		drop     = 1'b1;
		d.reason = reason_flag;
		if (disc)
			d.reason = reason_flag;
		else if (n == 0)
			d.reason = reason_empty_vec;
		else if (n == 1 && ucast_occ >= UCAST_CAP)
			d.reason = reason_queue_full;
		else if (n == 1)
		begin
			drop = 1'b0;
			ucast_occ++;
		end
		else if (!allow)
			d.reason = reason_mcast_blocked;
		else if (mcast_occ >= MCAST_CAP)
			d.reason = reason_queue_full;
		else
		begin
			drop = 1'b0;
			mcast_occ++;
		end
		if (drop)
		begin
			d.buf_ptr  = enq_buf_ptr;
			d.len      = enq_len;
			d.src_port = enq_src_port;
			d.due      = cyc + 2;   // Registered at N, reported from N+1 to N+2.
			disc_q.push_back(d);
		end
		else
		begin
			k = 0;
			for (int i = 0; i < CONN_NUM; i++)
			begin
				if (vec[i])
				begin
					c.ucast    = (n == 1);
					c.last     = (k == n - 1);
					c.copy_id  = copy_id_t'(k);
					c.qid      = {enq_pri, conn_id_t'(i)};
					c.buf_ptr  = enq_buf_ptr;
					c.len      = enq_len;
					c.src_port = enq_src_port;
					if (n == 1)
						ucopy_q.push_back(c);
					else
						mcopy_q.push_back(c);
					k++;
				end
			end
		end
		refresh_heads();
		@(negedge clk);
		enq_req = 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int t;
		t = 0;
		while ((ucopy_q.size() > 0 || mcopy_q.size() > 0 || disc_q.size() > 0) && t < limit)
		begin
			@(negedge clk);
			t++;
		end
		if (ucopy_q.size() > 0 || mcopy_q.size() > 0 || disc_q.size() > 0)
		begin
			$display("Timeout at %0t: a copy or discard never arrived", $time);
			$display("Errors found");
			$finish;
		end
	endtask

	task automatic finish_test(input string name);
		wait_drain(500);
		tests++;
		$display("Test %0d %s finished, errors so far %0d", tests, name, errors);
	endtask

	initial
	begin
		conn_vec_t vec;
		seed            = 11;
		cyc             = 0;
		errors          = 0;
		checks          = 0;
		tests           = 0;
		ucast_occ       = 0;
		mcast_occ       = 0;
		next_ptr        = 16'h100;
		in_pkt          = 1'b0;
		pkt_ucast       = 1'b0;
		rst_n           = 1'b0;
		enq_req         = 1'b0;
		enq_discard     = 1'b0;
		enq_allow_mcast = 1'b0;
		enq_vec         = '0;
		enq_pri         = '0;
		enq_buf_ptr     = '0;
		enq_len         = '0;
		enq_src_port    = '0;
		rep_bp          = 1'b0;
		refresh_heads();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < 4; i++)
			send_packet(1'b0, 1'b0, conn_vec_t'(1) << ($unsigned($random(seed)) % CONN_NUM));
		finish_test("unicast");

		for (int i = 0; i < 4; i++)
		begin
			vec = conn_vec_t'($random(seed)) | 16'h0101;   // At least two bits.
			send_packet(1'b0, 1'b1, vec);
		end
		finish_test("multicast");

		send_packet(1'b1, 1'b1, 16'h0010);
		send_packet(1'b0, 1'b1, 16'h0000);
		send_packet(1'b0, 1'b0, 16'h8421);
		finish_test("discard reasons");

		@(negedge clk);
		rep_bp = 1'b1;
		for (int i = 0; i < (1 << MCAST_DEPTH_BITS) + 3; i++)
			send_packet(1'b0, 1'b1, conn_vec_t'($random(seed)) | 16'h1001);
		repeat (10) @(negedge clk);
		rep_bp = 1'b0;
		finish_test("back-pressure");

		// Back to back, so unicast arrives while multicast is being copied.
		for (int i = 0; i < 8; i++)
		begin
			if ($random(seed) & 1)
				send_packet(1'b0, 1'b0, conn_vec_t'(1) << ($unsigned($random(seed)) % CONN_NUM));
			else
				send_packet(1'b0, 1'b1, conn_vec_t'($random(seed)) | 16'h0030);
		end
		finish_test("mixed");

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
verilog/replicator_pkg.sv
verilog/queue_if.sv
verilog/enq_classifier.sv
verilog/desc_fifo.sv
verilog/copy_engine.sv
verilog/packet_replicator.sv
bench/replicator_tb.sv
